/* hdl/iter_alloc.sv */
`timescale 1ns/1ps

module iter_alloc import loop_pkg::*; (
	input logic clk,
	input logic rst,
	input logic issue_fork,
	input fork_t fork_cfg,
	input logic [N_CORE-1:0] req,
	output logic [N_CORE-1:0] grant,
	output idx_t grant_idx [N_CORE],
	output logic empty
);
	alloc_state_e state;
	idx_t counter;
	idx_t stride;
	cnt_t remain;
	rank_t rank [N_CORE];
	rank_t n_grant;

	// Prefix count of requests from lower-numbered workers
	always_comb begin
		rank[0] = '0;
		for (int i = 1; i < N_CORE; i++) begin
			rank[i] = rank[i-1] + rank_t'(req[i-1]);
		end
	end

	// Requester k gets counter + k*stride while k is below the remaining count.
	// The product wraps modulo 2^32, so negative strides come out right
	always_comb begin
		n_grant = '0;
		for (int i = 0; i < N_CORE; i++) begin
			grant[i] = (state == ALLOC_RUN) && req[i] && (CNT_W'(rank[i]) < remain);
			grant_idx[i] = counter + idx_t'(rank[i]) * stride;
			n_grant = n_grant + rank_t'(grant[i]);
		end
	end

	assign empty = (remain == '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ALLOC_IDLE;
			remain <= '0;
		end else if (issue_fork) begin
			state <= (fork_cfg.count != '0) ? ALLOC_RUN : ALLOC_IDLE;
			remain <= fork_cfg.count;
		end else if (state == ALLOC_RUN) begin
			remain <= remain - CNT_W'(n_grant);
			// Last indices handed out this cycle
			if (remain == CNT_W'(n_grant)) begin
				state <= ALLOC_IDLE;
			end
		end
	end

	// Shared counter moves past every index granted this cycle
	always_ff @(posedge clk) begin
		if (issue_fork) begin
			counter <= fork_cfg.start;
			stride <= fork_cfg.stride;
		end else begin
			counter <= counter + idx_t'(n_grant) * stride;
		end
	end

endmodule

/* hdl/loop_csr.sv */
`timescale 1ns/1ps

module loop_csr import loop_pkg::*; (
	input logic clk,
	input logic rst,
	// AXI4-Lite slave
	input logic awvalid,
	output logic awready,
	input axi_addr_t awaddr,
	input logic wvalid,
	output logic wready,
	input axi_data_t wdata,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic arvalid,
	output logic arready,
	input axi_addr_t araddr,
	output logic rvalid,
	input logic rready,
	output axi_data_t rdata,
	output logic [1:0] rresp,
	// Loop control
	output fork_t fork_cfg,
	output logic issue_fork,
	input logic alloc_empty,
	input logic [N_CORE-1:0] workers_idle,
	input worker_res_t results [N_CORE]
);
	csr_wr_state_e wr_state;
	logic wr_accept;
	logic rd_accept;
	logic loop_quiet;
	logic busy;
	logic done;
	idx_t start_q;
	idx_t stride_q;
	cnt_t count_q;
	axi_data_t rd_mux;

	// Address and data are taken together, one write outstanding
	assign wr_accept = (wr_state == WR_IDLE) && awvalid && wvalid;
	assign awready = wr_accept;
	assign wready = wr_accept;
	assign bvalid = (wr_state == WR_RESP);
	assign bresp = AXI_OKAY;

	assign rd_accept = arvalid && !rvalid;
	assign arready = rd_accept;
	assign rresp = AXI_OKAY;

	assign fork_cfg = '{start: start_q, stride: stride_q, count: count_q};

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_state <= WR_IDLE;
		end else begin
			case (wr_state)
				WR_IDLE: begin
					if (wr_accept) begin
						wr_state <= WR_RESP;
					end
				end
				WR_RESP: begin
					if (bready) begin
						wr_state <= WR_IDLE;
					end
				end
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			start_q <= '0;
			stride_q <= '0;
			count_q <= '0;
		end else if (wr_accept) begin
			case (awaddr)
				REG_START: start_q <= wdata;
				REG_STRIDE: stride_q <= wdata;
				REG_COUNT: count_q <= wdata[CNT_W-1:0];
				default: ;
			endcase
		end
	end

	// Go is dropped while a loop runs, including the pulse cycle itself
	always_ff @(posedge clk) begin
		if (rst) begin
			issue_fork <= 1'b0;
		end else begin
			issue_fork <= wr_accept && (awaddr == REG_CTRL) && wdata[0]
				&& !busy && !issue_fork;
		end
	end

	// Loop finished when no indices remain and nobody holds one
	assign loop_quiet = alloc_empty && (&workers_idle);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else if (issue_fork) begin
			busy <= 1'b1;
			done <= 1'b0;
		end else if (busy && loop_quiet) begin
			busy <= 1'b0;
			done <= 1'b1;
		end
	end

	always_comb begin
		rd_mux = '0;
		case (araddr)
			REG_START: rd_mux = start_q;
			REG_STRIDE: rd_mux = stride_q;
			REG_COUNT: rd_mux = AXI_DATA_W'(count_q);
			REG_STATUS: rd_mux = AXI_DATA_W'({done, busy});
			default: ;
		endcase
		// Per-core result window
		for (int i = 0; i < N_CORE; i++) begin
			if (araddr == axi_addr_t'(REG_RES_BASE + i * REG_RES_STRIDE)) begin
				rd_mux = results[i].sum;
			end
			if (araddr == axi_addr_t'(REG_RES_BASE + i * REG_RES_STRIDE + 4)) begin
				rd_mux = AXI_DATA_W'(results[i].count);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid <= 1'b0;
		end else if (rd_accept) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_accept) begin
			rdata <= rd_mux;
		end
	end

endmodule

/* hdl/loop_pkg.sv */
package loop_pkg;

	// Worker count and datapath widths
	localparam int N_CORE = 4;
	localparam int IDX_W = 32;
	localparam int CNT_W = 16;
	localparam int SUM_W = 32;
	localparam int RANK_W = $clog2(N_CORE + 1);
	localparam int AXI_ADDR_W = 8;
	localparam int AXI_DATA_W = 32;

	typedef logic [IDX_W-1:0] idx_t;
	typedef logic [CNT_W-1:0] cnt_t;
	typedef logic [SUM_W-1:0] sum_t;
	typedef logic [RANK_W-1:0] rank_t;
	typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
	typedef logic [AXI_DATA_W-1:0] axi_data_t;

	// Register map, byte offsets
	localparam axi_addr_t REG_CTRL = 8'h00;
	localparam axi_addr_t REG_START = 8'h04;
	localparam axi_addr_t REG_STRIDE = 8'h08;
	localparam axi_addr_t REG_COUNT = 8'h0C;
	localparam axi_addr_t REG_STATUS = 8'h10;
	localparam axi_addr_t REG_RES_BASE = 8'h20;
	// Sum word at +0, count word at +4
	localparam int REG_RES_STRIDE = 8;

	localparam logic [1:0] AXI_OKAY = 2'b00;

	typedef struct packed {
		idx_t start;
		idx_t stride;
		cnt_t count;
	} fork_t;

	typedef struct packed {
		sum_t sum;
		cnt_t count;
	} worker_res_t;

	typedef enum logic {ALLOC_IDLE, ALLOC_RUN} alloc_state_e;
	typedef enum logic {WR_IDLE, WR_RESP} csr_wr_state_e;

endpackage

/* hdl/loop_top.sv */
`timescale 1ns/1ps

module loop_top import loop_pkg::*; (
	input logic clk,
	input logic rst,
	input logic awvalid,
	output logic awready,
	input axi_addr_t awaddr,
	input logic wvalid,
	output logic wready,
	input axi_data_t wdata,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic arvalid,
	output logic arready,
	input axi_addr_t araddr,
	output logic rvalid,
	input logic rready,
	output axi_data_t rdata,
	output logic [1:0] rresp
);
	fork_t fork_cfg;
	logic issue_fork;
	logic alloc_empty;
	logic [N_CORE-1:0] req;
	logic [N_CORE-1:0] grant;
	logic [N_CORE-1:0] workers_idle;
	idx_t grant_idx [N_CORE];
	worker_res_t results [N_CORE];

	// Register block, source of forks
	loop_csr i_loop_csr (
		.clk,
		.rst,
		.awvalid,
		.awready,
		.awaddr,
		.wvalid,
		.wready,
		.wdata,
		.bvalid,
		.bready,
		.bresp,
		.arvalid,
		.arready,
		.araddr,
		.rvalid,
		.rready,
		.rdata,
		.rresp,
		.fork_cfg,
		.issue_fork,
		.alloc_empty,
		.workers_idle,
		.results
	);

	iter_alloc i_iter_alloc (
		.clk,
		.rst,
		.issue_fork,
		.fork_cfg,
		.req,
		.grant,
		.grant_idx,
		.empty(alloc_empty)
	);

	for (genvar i = 0; i < N_CORE; i++) begin : g_worker
		loop_worker i_loop_worker (
			.clk,
			.rst,
			.issue_fork,
			.req(req[i]),
			.grant(grant[i]),
			.grant_idx(grant_idx[i]),
			.idle(workers_idle[i]),
			.result(results[i])
		);
	end

endmodule

/* hdl/loop_worker.sv */
`timescale 1ns/1ps

module loop_worker import loop_pkg::*; (
	input logic clk,
	input logic rst,
	input logic issue_fork,
	output logic req,
	input logic grant,
	input idx_t grant_idx,
	output logic idle,
	output worker_res_t result
);
	logic armed;
	logic working;
	logic [1:0] wait_cnt;
	logic finish;
	idx_t idx_q;
	sum_t sum_q;
	cnt_t count_q;

	// Ask for work once a fork has been seen and no index is held
	assign req = armed && !working;
	assign idle = !working;
	assign finish = working && (wait_cnt == 2'd0);

	assign result = '{sum: sum_q, count: count_q};

	always_ff @(posedge clk) begin
		if (rst) begin
			armed <= 1'b0;
			working <= 1'b0;
			wait_cnt <= 2'd0;
		end else begin
			if (issue_fork) begin
				armed <= 1'b1;
			end
			if (req && grant) begin
				// Work time is 1 + low two bits of the index
				working <= 1'b1;
				wait_cnt <= grant_idx[1:0];
			end else if (finish) begin
				working <= 1'b0;
			end else if (working) begin
				wait_cnt <= wait_cnt - 2'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req && grant) begin
			idx_q <= grant_idx;
		end
	end

	// Results restart with every fork
	always_ff @(posedge clk) begin
		if (rst || issue_fork) begin
			sum_q <= '0;
			count_q <= '0;
		end else if (finish) begin
			sum_q <= sum_q + idx_q;
			count_q <= count_q + cnt_t'(1);
		end
	end

endmodule

/* loop_dispatch.f */
hdl/loop_pkg.sv
hdl/loop_csr.sv
hdl/iter_alloc.sv
hdl/loop_worker.sv
hdl/loop_top.sv
sim/loop_top_props.sv
sim/loop_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the loop dispatcher testbench with Verilator
verilator --binary --timing --assert -f loop_dispatch.f --top-module loop_top_tb \
	-Mdir obj_dir > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/Vloop_top_tb > sim.log 2>&1
grep -q "Finished with errors" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
exit 0

/* sim/loop_cases.txt */
# start stride count expected_sum expected_count, all hex
# expected_sum wraps modulo 2^32 over start + i*stride for i below count
00000000 00000001 0000000a 0000002d 0000000a
00000064 00000003 00000014 00000a0a 00000014
000003e8 fffffffe 00000010 00003d90 00000010
00000005 00000007 00000000 00000000 00000000
fffffff0 00000001 00000021 00000000 00000021
00000010 00000000 00000007 00000070 00000007
7ffffff0 00000010 00000005 80000050 00000005
00000000 fffffffb 00000064 ffff9f52 00000064
0000000a fffffff6 00000003 00000000 00000003
00000001 00000001 00000001 00000001 00000001
00001000 00000100 00000040 000be000 00000040

/* sim/loop_top_props.sv */
`timescale 1ns/1ps

module loop_top_props import loop_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [N_CORE-1:0] req,
	input logic [N_CORE-1:0] grant,
	input logic [N_CORE-1:0][IDX_W-1:0] idx,
	input idx_t stride,
	input cnt_t remain,
	input logic issue_fork,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready
);

	// Distinct indices within one cycle
	for (genvar i = 0; i < N_CORE; i++) begin : g_a
		for (genvar j = i + 1; j < N_CORE; j++) begin : g_b
			assert property (@(posedge clk) disable iff (rst)
				grant[i] && grant[j] && (stride != '0) |-> idx[i] != idx[j])
				else $error("Two workers got the same index");
		end
	end

	// Grants go only to requesters and never outnumber the remaining iterations
	assert property (@(posedge clk) disable iff (rst)
		((grant & ~req) == '0) && ($countones(grant) <= int'(remain)))
		else $error("Grant without a request or beyond the loop");

	assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	assert property (@(posedge clk) disable iff (rst) issue_fork |=> !issue_fork)
		else $error("issue_fork longer than one cycle");

endmodule

// Allocator side with the AXI inputs tied idle
bind iter_alloc loop_top_props i_alloc_props (
	.clk, .rst, .req, .grant,
	.idx({grant_idx[3], grant_idx[2], grant_idx[1], grant_idx[0]}),
	.stride, .remain, .issue_fork,
	.bvalid(1'b0), .bready(1'b1), .rvalid(1'b0), .rready(1'b1)
);

bind loop_csr loop_top_props i_csr_props (
	.clk, .rst, .req('0), .grant('0), .idx('0), .stride('0), .remain('0),
	.issue_fork, .bvalid, .bready, .rvalid, .rready
);

/* sim/loop_top_tb.sv */
`timescale 1ns/1ps

module loop_top_tb import loop_pkg::*; ();

	localparam int WAIT_LIMIT = 200;
	localparam int POLL_LIMIT = 500;

	logic clk;
	logic rst;
	logic awvalid;
	logic awready;
	axi_addr_t awaddr;
	logic wvalid;
	logic wready;
	axi_data_t wdata;
	logic bvalid;
	logic bready;
	logic [1:0] bresp;
	logic arvalid;
	logic arready;
	axi_addr_t araddr;
	logic rvalid;
	logic rready;
	axi_data_t rdata;
	logic [1:0] rresp;

	int error_count;
	int timeout_count;
	logic [31:0] lfsr;

	loop_top i_loop_top (.*);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			error_count++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic stop_on_timeout(input string what);
		timeout_count++;
		$display("Timed out waiting for %s", what);
		$display("Errors: %0d failed checks, %0d timeouts", error_count, timeout_count);
		$display("Finished with errors");
		$finish;
	endtask

	task automatic axi_write(input axi_addr_t addr, input axi_data_t data);
		int n;
		int hold;
		@(posedge clk);
		awvalid <= 1'b1;
		awaddr <= addr;
		wvalid <= 1'b1;
		wdata <= data;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!awready && n < WAIT_LIMIT);
		if (!awready) stop_on_timeout("write address accept");
		// Data channel is taken in the same cycle as the address
		check_value("wready", 32'(wready), 32'h1);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		// Random back-pressure on the write response
		hold = take_bits(2);
		repeat (hold) @(posedge clk);
		bready <= 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!bvalid && n < WAIT_LIMIT);
		if (!bvalid) stop_on_timeout("write response");
		check_value("bresp", 32'(bresp), 32'(AXI_OKAY));
		bready <= 1'b0;
	endtask

	task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
		int n;
		int hold;
		@(posedge clk);
		arvalid <= 1'b1;
		araddr <= addr;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!arready && n < WAIT_LIMIT);
		if (!arready) stop_on_timeout("read address accept");
		arvalid <= 1'b0;
		hold = take_bits(2);
		repeat (hold) @(posedge clk);
		rready <= 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!rvalid && n < WAIT_LIMIT);
		if (!rvalid) stop_on_timeout("read data");
		data = rdata;
		check_value("rresp", 32'(rresp), 32'(AXI_OKAY));
		rready <= 1'b0;
	endtask

	task automatic run_case(input idx_t start, input idx_t stride, input cnt_t count,
			input sum_t exp_sum, input cnt_t exp_count);
		axi_data_t rd;
		sum_t sum_total;
		logic [31:0] count_total;
		int polls;
		axi_write(REG_START, start);
		axi_write(REG_STRIDE, stride);
		axi_write(REG_COUNT, 32'(count));
		axi_read(REG_START, rd);
		check_value("START", rd, start);
		axi_read(REG_STRIDE, rd);
		check_value("STRIDE", rd, stride);
		axi_read(REG_COUNT, rd);
		check_value("COUNT", rd, 32'(count));
		axi_write(REG_CTRL, 32'h1);
		// Second go lands while the loop runs and must be dropped
		axi_write(REG_CTRL, 32'h1);
		polls = 0;
		do begin
			axi_read(REG_STATUS, rd);
			polls++;
		end while (!rd[1] && polls < POLL_LIMIT);
		if (!rd[1]) stop_on_timeout("STATUS done");
		check_value("STATUS", rd, 32'h2);
		sum_total = '0;
		count_total = '0;
		for (int i = 0; i < N_CORE; i++) begin
			axi_read(axi_addr_t'(REG_RES_BASE + i * REG_RES_STRIDE), rd);
			sum_total = sum_total + rd;
			if (count == '0) check_value("worker sum", rd, 32'h0);
			axi_read(axi_addr_t'(REG_RES_BASE + i * REG_RES_STRIDE + 4), rd);
			count_total = count_total + rd;
			if (count == '0) check_value("worker count", rd, 32'h0);
		end
		check_value("total count", count_total, 32'(exp_count));
		check_value("total sum", sum_total, exp_sum);
	endtask

	initial begin
		int fd;
		int n_cases;
		string line;
		axi_data_t rd;
		logic [31:0] f_start;
		logic [31:0] f_stride;
		logic [31:0] f_count;
		logic [31:0] f_sum;
		logic [31:0] f_total;
		error_count = 0;
		timeout_count = 0;
		n_cases = 0;
		lfsr = 32'h69bf;
		rst = 1'b1;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		axi_read(REG_STATUS, rd);
		check_value("STATUS after reset", rd, 32'h0);

		fd = $fopen("sim/loop_cases.txt", "r");
		if (fd == 0) begin
			error_count++;
			$display("Could not open the case file sim/loop_cases.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// Skip blank and comment lines
				if (line.len() < 5 || line[0] == "#") continue;
				if ($sscanf(line, "%h %h %h %h %h", f_start, f_stride, f_count,
						f_sum, f_total) != 5) begin
					error_count++;
					$display("Malformed case line: %s", line);
					continue;
				end
				run_case(f_start, f_stride, cnt_t'(f_count), f_sum, cnt_t'(f_total));
				n_cases++;
			end
			$fclose(fd);
		end
		if (n_cases == 0) begin
			error_count++;
			$display("No cases were run");
		end

		repeat (4) @(posedge clk);
		$display("Errors: %0d failed checks, %0d timeouts", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
